// File: source/riscv_cfg.svh
// memory stage configuration macros, include wherever widths, depth or CSR addresses are needed
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// datapath width
`define XLEN 32

// data memory depth in 32-bit words
`define DMEM_WORDS 256

// machine-mode CSR addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC    12'h305
`define CSR_MCAUSE   12'h342

`endif

// File: source/riscv_pkg.sv
// shared RV32I memory-stage types; import into any block that uses opcodes or trap causes
package riscv_pkg;

    // memory opcode carried from EX/MEM into the memory stage
    typedef enum logic [3:0]
    {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LBU = 4'd2,
        MEM_LH  = 4'd3,
        MEM_LHU = 4'd4,
        MEM_LW  = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

    // trap causes, each encoded as its machine-mode mcause code
    typedef enum logic [3:0]
    {
        EXC_NONE          = 4'd0,
        EXC_ILLEGAL_INSTR = 4'd2,
        EXC_BREAKPOINT    = 4'd3,
        EXC_LOAD_FAULT    = 4'd5,
        EXC_STORE_FAULT   = 4'd7,
        EXC_ECALL_M       = 4'd11
    } exc_t;

endpackage: riscv_pkg

// File: source/data_mem.sv
// word-organized data RAM, combinational read and byte-lane write, driven by the memory stage
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module data_mem
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic [`XLEN-1:0]  addr_i,
    input  logic              read_i,
    input  logic [3:0]        wsel_byte_i,
    input  logic [`XLEN-1:0]  wdata_i,
    output logic [`XLEN-1:0]  rdata_o
);

    localparam int IDX_BITS = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]    mem [`DMEM_WORDS];
    logic [IDX_BITS-1:0] word_idx;

    // byte offset dropped, upper bits beyond the depth ignored
    assign word_idx = addr_i[IDX_BITS+1:2];

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int w = 0; w < `DMEM_WORDS; w++)
            begin
                mem[w] <= '0;
            end
        end
        else
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (wsel_byte_i[b])
                begin
                    mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = read_i ? mem[word_idx] : '0;

endmodule: data_mem

// File: source/mem_rw.sv
// memory-access stage: load/store lane handling, CSR and trap forwarding, MEM/WB registers
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module mem_rw
import riscv_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,

    // data memory side
    output logic [`XLEN-1:0]  rw_addr_o,
    output logic              read_o,
    input  logic [`XLEN-1:0]  rdata_i,
    output logic [3:0]        wsel_byte_o,
    output logic [`XLEN-1:0]  wdata_o,

    // CSR file side
    output logic [`XLEN-1:0]  csr_wdata_o,
    output logic [11:0]       csr_waddr_o,
    output logic              csr_we_o,
    output exc_t              trap_o,

    // EX/MEM fields
    input  logic [`XLEN-1:0]  alu_result_i,
    input  logic [`XLEN-1:0]  alu_oper2_i,
    input  mem_oper_t         mem_oper_i,
    input  logic [`XLEN-1:0]  csr_wdata_i,
    input  logic [11:0]       csr_waddr_i,
    input  logic              csr_we_i,
    input  exc_t              trap_i,
    input  logic              wb_use_mem_i,
    input  logic              write_rd_i,
    input  logic [4:0]        rd_addr_i,

    // MEM/WB registers
    output logic              wb_use_mem_o,
    output logic              write_rd_o,
    output logic [4:0]        rd_addr_o,
    output logic [`XLEN-1:0]  alu_result_o,
    output logic [`XLEN-1:0]  dmem_rdata_o
);

    // shift amounts that move a byte or halfword lane down to bit 0
    logic [4:0]       byte_shift;
    logic [4:0]       half_shift;
    logic [`XLEN-1:0] byte_word;
    logic [`XLEN-1:0] half_word;
    logic [`XLEN-1:0] load_data;

    // unaligned low bits are simply dropped
    assign byte_shift = {alu_result_i[1:0], 3'b000};
    assign half_shift = {alu_result_i[1], 4'b0000};
    assign byte_word  = rdata_i >> byte_shift;
    assign half_word  = rdata_i >> half_shift;

    always_comb
    begin
        read_o      = 1'b0;
        wsel_byte_o = 4'b0000;
        wdata_o     = '0;
        load_data   = '0;

        case (mem_oper_i)
            MEM_LB:
            begin
                read_o    = 1'b1;
                load_data = {{24{byte_word[7]}}, byte_word[7:0]};
            end
            MEM_LBU:
            begin
                read_o    = 1'b1;
                load_data = {24'b0, byte_word[7:0]};
            end
            MEM_LH:
            begin
                read_o    = 1'b1;
                load_data = {{16{half_word[15]}}, half_word[15:0]};
            end
            MEM_LHU:
            begin
                read_o    = 1'b1;
                load_data = {16'b0, half_word[15:0]};
            end
            MEM_LW:
            begin
                read_o    = 1'b1;
                load_data = rdata_i;
            end
            // store data is moved up into its own lane
            MEM_SB:
            begin
                wsel_byte_o = 4'b0001 << alu_result_i[1:0];
                wdata_o     = alu_oper2_i << byte_shift;
            end
            MEM_SH:
            begin
                wsel_byte_o = 4'b0011 << {alu_result_i[1], 1'b0};
                wdata_o     = alu_oper2_i << half_shift;
            end
            MEM_SW:
            begin
                wsel_byte_o = 4'b1111;
                wdata_o     = alu_oper2_i;
            end
            default:
            begin
            end
        endcase
    end

    assign rw_addr_o = (mem_oper_i == MEM_NOP) ? '0 : alu_result_i;

    // CSR writes and traps take effect in the CSR file this cycle
    assign csr_we_o    = csr_we_i;
    assign csr_waddr_o = csr_waddr_i;
    assign csr_wdata_o = csr_wdata_i;
    assign trap_o      = trap_i;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wb_use_mem_o <= 1'b0;
            write_rd_o   <= 1'b0;
            rd_addr_o    <= '0;
            alu_result_o <= '0;
            dmem_rdata_o <= '0;
        end
        else
        begin
            wb_use_mem_o <= wb_use_mem_i;
            write_rd_o   <= write_rd_i;
            rd_addr_o    <= rd_addr_i;
            alu_result_o <= alu_result_i;
            dmem_rdata_o <= load_data;
        end
    end

endmodule: mem_rw

// File: source/csr_file.sv
// machine-mode CSRs mscratch, mtvec and mcause, written by the memory stage and read for observation
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module csr_file
import riscv_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              csr_we_i,
    input  logic [11:0]       csr_waddr_i,
    input  logic [`XLEN-1:0]  csr_wdata_i,
    input  exc_t              trap_i,
    input  logic [11:0]       csr_raddr_i,
    output logic [`XLEN-1:0]  csr_rdata_o
);

    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mcause;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            mscratch <= '0;
            mtvec    <= '0;
            mcause   <= '0;
        end
        else
        begin
            if (csr_we_i)
            begin
                case (csr_waddr_i)
                    `CSR_MSCRATCH: mscratch <= csr_wdata_i;
                    `CSR_MTVEC:    mtvec    <= csr_wdata_i;
                    `CSR_MCAUSE:   mcause   <= csr_wdata_i;
                    default:
                    begin
                    end
                endcase
            end
            // trap capture overrides a same-cycle mcause write
            if (trap_i != EXC_NONE)
            begin
                mcause <= `XLEN'(trap_i);
            end
        end
    end

    always_comb
    begin
        case (csr_raddr_i)
            `CSR_MSCRATCH: csr_rdata_o = mscratch;
            `CSR_MTVEC:    csr_rdata_o = mtvec;
            `CSR_MCAUSE:   csr_rdata_o = mcause;
            default:       csr_rdata_o = '0;
        endcase
    end

endmodule: csr_file

// File: source/wb_regfile.sv
// writeback select and 32-entry general register file with one combinational read port
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module wb_regfile
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              wb_use_mem_i,
    input  logic              write_rd_i,
    input  logic [4:0]        rd_addr_i,
    input  logic [`XLEN-1:0]  alu_result_i,
    input  logic [`XLEN-1:0]  dmem_rdata_i,
    input  logic [4:0]        rs_addr_i,
    output logic [`XLEN-1:0]  rs_data_o
);

    logic [`XLEN-1:0] regs [32];
    logic [`XLEN-1:0] wb_data;

    // load result or ALU result
    assign wb_data = wb_use_mem_i ? dmem_rdata_i : alu_result_i;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int r = 0; r < 32; r++)
            begin
                regs[r] <= '0;
            end
        end
        else if (write_rd_i && (rd_addr_i != 5'd0))
        begin
            regs[rd_addr_i] <= wb_data;
        end
    end

    // x0 hardwired to zero
    assign rs_data_o = (rs_addr_i == 5'd0) ? '0 : regs[rs_addr_i];

endmodule: wb_regfile

// File: source/mem_stage_top.sv
// memory and writeback end of the pipeline: stage, data RAM, CSR file and register file
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module mem_stage_top
import riscv_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,

    // EX/MEM stand-ins
    input  logic [`XLEN-1:0]  alu_result_i,
    input  logic [`XLEN-1:0]  alu_oper2_i,
    input  mem_oper_t         mem_oper_i,
    input  logic [`XLEN-1:0]  csr_wdata_i,
    input  logic [11:0]       csr_waddr_i,
    input  logic              csr_we_i,
    input  exc_t              trap_i,
    input  logic              wb_use_mem_i,
    input  logic              write_rd_i,
    input  logic [4:0]        rd_addr_i,

    // observation ports
    input  logic [4:0]        rs_addr_i,
    output logic [`XLEN-1:0]  rs_data_o,
    input  logic [11:0]       csr_raddr_i,
    output logic [`XLEN-1:0]  csr_rdata_o
);

    logic [`XLEN-1:0] rw_addr;
    logic             read;
    logic [`XLEN-1:0] rdata;
    logic [3:0]       wsel_byte;
    logic [`XLEN-1:0] wdata;

    logic [`XLEN-1:0] csr_wdata;
    logic [11:0]      csr_waddr;
    logic             csr_we;
    exc_t             trap;

    // MEM/WB
    logic             wb_use_mem;
    logic             write_rd;
    logic [4:0]       rd_addr;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] dmem_rdata;

    mem_rw u_mem_rw
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rw_addr_o    (rw_addr),
        .read_o       (read),
        .rdata_i      (rdata),
        .wsel_byte_o  (wsel_byte),
        .wdata_o      (wdata),
        .csr_wdata_o  (csr_wdata),
        .csr_waddr_o  (csr_waddr),
        .csr_we_o     (csr_we),
        .trap_o       (trap),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .mem_oper_i   (mem_oper_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_we_i     (csr_we_i),
        .trap_i       (trap_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .wb_use_mem_o (wb_use_mem),
        .write_rd_o   (write_rd),
        .rd_addr_o    (rd_addr),
        .alu_result_o (alu_result),
        .dmem_rdata_o (dmem_rdata)
    );

    data_mem u_dmem
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .addr_i      (rw_addr),
        .read_i      (read),
        .wsel_byte_i (wsel_byte),
        .wdata_i     (wdata),
        .rdata_o     (rdata)
    );

    csr_file u_csr
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .csr_we_i    (csr_we),
        .csr_waddr_i (csr_waddr),
        .csr_wdata_i (csr_wdata),
        .trap_i      (trap),
        .csr_raddr_i (csr_raddr_i),
        .csr_rdata_o (csr_rdata_o)
    );

    wb_regfile u_rf
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .wb_use_mem_i (wb_use_mem),
        .write_rd_i   (write_rd),
        .rd_addr_i    (rd_addr),
        .alu_result_i (alu_result),
        .dmem_rdata_i (dmem_rdata),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o)
    );

endmodule: mem_stage_top

// File: sim/mem_stage_properties.sv
// concurrent checks on the memory stage lane control and MEM/WB reset state, bound into mem_rw
`timescale 1ns/100ps

module mem_stage_properties
import riscv_pkg::*;
(
    input logic       clk_i,
    input logic       rstn_i,
    input logic       read_i,
    input logic [3:0] wsel_byte_i,
    input mem_oper_t  mem_oper_i,
    input logic       write_rd_i
);

    // a load and a store never share a cycle
    no_read_and_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(read_i && (wsel_byte_i != 4'b0000)))
        else $error("read strobe and byte write enables active in the same cycle");

    nop_no_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (mem_oper_i == MEM_NOP) |-> (wsel_byte_i == 4'b0000))
        else $error("byte write enables set for a NOP");

    // MEM/WB leaves reset with the writeback strobe cleared
    rd_idle_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !write_rd_i)
        else $error("write_rd set in the first cycle after reset");

endmodule: mem_stage_properties

// File: sim/mem_stage_tb.sv
// self-checking testbench for mem_stage_top, LFSR stimulus compared against a behavioral model
`timescale 1ns/100ps
`include "riscv_cfg.svh"

module mem_stage_tb
import riscv_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int N_WORD = 16;
    localparam int N_LANE = 16;
    localparam int N_EXT  = 8;
    localparam int N_ALU  = 16;
    localparam int N_CSR  = 24;
    localparam int N_MIX  = 48;
    // upper bound on cycles per item of each test
    localparam int TOTAL_OPS = RESET_CYCLES + 5*N_WORD + 6*N_LANE + 27*N_EXT + 5*N_ALU
                             + 5*N_CSR + N_MIX + 34 + 8;
    localparam int WATCHDOG_NS = TOTAL_OPS * 40 + 2000;
    localparam logic [11:0] CSR_UNMAPPED = 12'h7C0;

    logic              clk_i;
    logic              rstn_i;
    logic [`XLEN-1:0]  alu_result_i;
    logic [`XLEN-1:0]  alu_oper2_i;
    mem_oper_t         mem_oper_i;
    logic [`XLEN-1:0]  csr_wdata_i;
    logic [11:0]       csr_waddr_i;
    logic              csr_we_i;
    exc_t              trap_i;
    logic              wb_use_mem_i;
    logic              write_rd_i;
    logic [4:0]        rd_addr_i;
    logic [4:0]        rs_addr_i;
    logic [`XLEN-1:0]  rs_data_o;
    logic [11:0]       csr_raddr_i;
    logic [`XLEN-1:0]  csr_rdata_o;

    // reference model state
    logic [31:0] m_mem [`DMEM_WORDS];
    logic [31:0] m_regs [32];
    logic [31:0] m_mscratch;
    logic [31:0] m_mtvec;
    logic [31:0] m_mcause;

    logic [31:0] lfsr = 32'd62;
    int          errors = 0;
    int          checks = 0;

    mem_stage_top dut0
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .alu_result_i (alu_result_i),
        .alu_oper2_i  (alu_oper2_i),
        .mem_oper_i   (mem_oper_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_we_i     (csr_we_i),
        .trap_i       (trap_i),
        .wb_use_mem_i (wb_use_mem_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o),
        .csr_raddr_i  (csr_raddr_i),
        .csr_rdata_o  (csr_rdata_o)
    );

    bind mem_rw mem_stage_properties u_props
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .read_i      (read_o),
        .wsel_byte_i (wsel_byte_o),
        .mem_oper_i  (mem_oper_i),
        .write_rd_i  (write_rd_o)
    );

    always #20 clk_i = ~clk_i;

    // galois LFSR on x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return (addr >> 2) % `DMEM_WORDS;
    endfunction

    // mcause codes from the privileged spec
    function automatic logic [31:0] cause_code(input exc_t cause);
        case (cause)
            EXC_ILLEGAL_INSTR: return 32'd2;
            EXC_BREAKPOINT:    return 32'd3;
            EXC_LOAD_FAULT:    return 32'd5;
            EXC_STORE_FAULT:   return 32'd7;
            EXC_ECALL_M:       return 32'd11;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input mem_oper_t op, input logic [31:0] addr);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = m_mem[word_index(addr)];
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            MEM_LW:  return w;
            default: return 32'd0;
        endcase
    endfunction

    function automatic void store_model(input mem_oper_t op, input logic [31:0] addr,
                                        input logic [31:0] data);
        int idx;
        idx = word_index(addr);
        case (op)
            MEM_SB:  m_mem[idx][8*addr[1:0] +: 8] = data[7:0];
            MEM_SH:  m_mem[idx][16*addr[1] +: 16] = data[15:0];
            MEM_SW:  m_mem[idx] = data;
            default:
            begin
            end
        endcase
    endfunction

    function automatic logic [31:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MCAUSE:   return m_mcause;
            default:       return 32'd0;
        endcase
    endfunction

    // aligned random address with idx_bits of word index
    function automatic logic [31:0] pick_addr(input mem_oper_t op, input int idx_bits);
        logic [31:0] a;
        a = rand_bits(idx_bits) << 2;
        if (op inside {MEM_LB, MEM_LBU, MEM_SB})
        begin
            a = a | rand_bits(2);
        end
        else if (op inside {MEM_LH, MEM_LHU, MEM_SH})
        begin
            a = a | (rand_bits(1) << 1);
        end
        return a;
    endfunction

    function automatic mem_oper_t pick_load();
        case (rand_bits(3) % 5)
            0:       return MEM_LB;
            1:       return MEM_LBU;
            2:       return MEM_LH;
            3:       return MEM_LHU;
            default: return MEM_LW;
        endcase
    endfunction

    function automatic mem_oper_t pick_store();
        case (rand_bits(2))
            0:       return MEM_SB;
            1:       return MEM_SH;
            default: return MEM_SW;
        endcase
    endfunction

    function automatic exc_t pick_trap();
        case (rand_bits(3) % 5)
            0:       return EXC_ILLEGAL_INSTR;
            1:       return EXC_BREAKPOINT;
            2:       return EXC_LOAD_FAULT;
            3:       return EXC_STORE_FAULT;
            default: return EXC_ECALL_M;
        endcase
    endfunction

    // one EX/MEM slot per call; the model runs in program order
    task automatic issue(input mem_oper_t op, input logic [31:0] alu, input logic [31:0] op2,
                         input logic use_mem, input logic wr, input logic [4:0] rd,
                         input logic cwe, input logic [11:0] caddr, input logic [31:0] cdata,
                         input exc_t trap);
        logic [31:0] wb;
        @(posedge clk_i);
        mem_oper_i   <= op;
        alu_result_i <= alu;
        alu_oper2_i  <= op2;
        wb_use_mem_i <= use_mem;
        write_rd_i   <= wr;
        rd_addr_i    <= rd;
        csr_we_i     <= cwe;
        csr_waddr_i  <= caddr;
        csr_wdata_i  <= cdata;
        trap_i       <= trap;
        wb = use_mem ? load_value(op, alu) : alu;
        store_model(op, alu, op2);
        if (wr && (rd != 5'd0))
        begin
            m_regs[rd] = wb;
        end
        if (cwe)
        begin
            case (caddr)
                `CSR_MSCRATCH: m_mscratch = cdata;
                `CSR_MTVEC:    m_mtvec = cdata;
                `CSR_MCAUSE:   m_mcause = cdata;
                default:
                begin
                end
            endcase
        end
        // trap beats a same-cycle mcause write
        if (trap != EXC_NONE)
        begin
            m_mcause = cause_code(trap);
        end
    endtask

    task automatic idle();
        issue(MEM_NOP, 32'd0, 32'd0, 1'b0, 1'b0, 5'd0, 1'b0, 12'd0, 32'd0, EXC_NONE);
    endtask

    // lets the last result cross MEM/WB into the register file
    task automatic drain();
        idle();
        idle();
    endtask

    task automatic mem_op(input mem_oper_t op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [4:0] rd);
        logic ld;
        ld = op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        issue(op, addr, data, ld, ld, rd, 1'b0, 12'd0, 32'd0, EXC_NONE);
    endtask

    task automatic alu_op(input logic [4:0] rd, input logic [31:0] value, input logic wr);
        issue(MEM_NOP, value, 32'd0, 1'b0, wr, rd, 1'b0, 12'd0, 32'd0, EXC_NONE);
    endtask

    task automatic csr_op(input logic we, input logic [11:0] addr, input logic [31:0] data,
                          input exc_t trap);
        issue(MEM_NOP, 32'd0, 32'd0, 1'b0, 1'b0, 5'd0, we, addr, data, trap);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %08h, got %08h", $time, what, exp, act);
        end
    endtask

    task automatic check_reg(input logic [4:0] idx);
        idle();
        rs_addr_i <= idx;
        @(negedge clk_i);
        check_value($sformatf("x%0d", idx), m_regs[idx], rs_data_o);
    endtask

    task automatic check_csr(input logic [11:0] addr);
        idle();
        csr_raddr_i <= addr;
        @(negedge clk_i);
        check_value($sformatf("csr %03h", addr), csr_model_read(addr), csr_rdata_o);
    endtask

    task automatic report(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    task automatic word_roundtrip();
        int          c0;
        int          e0;
        logic [31:0] a;
        logic [31:0] d;
        logic [4:0]  rd;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_WORD; i++)
        begin
            a  = pick_addr(MEM_SW, 8);
            d  = rand_bits(32);
            rd = rand_bits(4) + 5'd1;
            mem_op(MEM_SW, a, d, 5'd0);
            mem_op(MEM_LW, a, 32'd0, rd);
            drain();
            check_reg(rd);
        end
        report("word store and load", c0, e0);
    endtask

    task automatic lane_stores();
        int          c0;
        int          e0;
        mem_oper_t   op;
        logic [31:0] a;
        logic [31:0] fill;
        logic [31:0] d;
        logic [4:0]  rd;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_LANE; i++)
        begin
            op   = rand_bits(1) ? MEM_SH : MEM_SB;
            a    = pick_addr(op, 8);
            fill = rand_bits(32);
            d    = rand_bits(32);
            rd   = rand_bits(4) + 5'd1;
            // known background word so untouched lanes can be seen
            mem_op(MEM_SW, a & ~32'h3, fill, 5'd0);
            mem_op(op, a, d, 5'd0);
            mem_op(MEM_LW, a & ~32'h3, 32'd0, rd);
            drain();
            check_reg(rd);
        end
        report("byte and halfword lanes", c0, e0);
    endtask

    task automatic load_extension();
        int          c0;
        int          e0;
        logic [31:0] base;
        logic [4:0]  rd;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_EXT; i++)
        begin
            base = pick_addr(MEM_SW, 8);
            rd   = 5'd1;
            mem_op(MEM_SW, base, rand_bits(32), 5'd0);
            for (int off = 0; off < 4; off++)
            begin
                mem_op(MEM_LB, base + off, 32'd0, rd);
                mem_op(MEM_LBU, base + off, 32'd0, rd + 5'd1);
                rd = rd + 5'd2;
            end
            for (int off = 0; off < 4; off += 2)
            begin
                mem_op(MEM_LH, base + off, 32'd0, rd);
                mem_op(MEM_LHU, base + off, 32'd0, rd + 5'd1);
                rd = rd + 5'd2;
            end
            drain();
            for (int r = 1; r < 13; r++)
            begin
                check_reg(r);
            end
        end
        report("load extension", c0, e0);
    endtask

    task automatic alu_writeback();
        int          c0;
        int          e0;
        logic [4:0]  rd;
        logic        wr;
        logic [31:0] v;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_ALU; i++)
        begin
            // first item writes x0, second holds a real register
            if (i == 0)
            begin
                rd = 5'd0;
                wr = 1'b1;
            end
            else if (i == 1)
            begin
                rd = rand_bits(4) + 5'd1;
                wr = 1'b0;
            end
            else
            begin
                rd = rand_bits(5);
                wr = rand_bits(2) != 0;
            end
            v  = rand_bits(32);
            alu_op(rd, v, wr);
            drain();
            check_reg(rd);
            check_reg(5'd0);
        end
        report("alu writeback and x0", c0, e0);
    endtask

    task automatic csr_traps();
        int          c0;
        int          e0;
        logic [11:0] addr;
        logic        we;
        logic [31:0] d;
        exc_t        trap;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_CSR; i++)
        begin
            case (rand_bits(2))
                0:       addr = `CSR_MSCRATCH;
                1:       addr = `CSR_MTVEC;
                2:       addr = `CSR_MCAUSE;
                default: addr = CSR_UNMAPPED;
            endcase
            we   = rand_bits(2) != 0;
            d    = rand_bits(32);
            trap = (rand_bits(2) == 0) ? pick_trap() : EXC_NONE;
            // last item forces the trap against an mcause write
            if (i == N_CSR - 1)
            begin
                addr = `CSR_MCAUSE;
                we   = 1'b1;
                trap = pick_trap();
            end
            csr_op(we, addr, d, trap);
            check_csr(`CSR_MSCRATCH);
            check_csr(`CSR_MTVEC);
            check_csr(`CSR_MCAUSE);
            check_csr(CSR_UNMAPPED);
        end
        report("csr writes and traps", c0, e0);
    endtask

    task automatic mixed_stream();
        int          c0;
        int          e0;
        mem_oper_t   op;
        logic [31:0] a;
        logic [31:0] d;
        logic [4:0]  rd;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_MIX; i++)
        begin
            case (rand_bits(2))
                0:
                begin
                    op = pick_store();
                    a  = pick_addr(op, 3);
                    d  = rand_bits(32);
                    mem_op(op, a, d, 5'd0);
                end
                2:
                begin
                    rd = rand_bits(5);
                    d  = rand_bits(32);
                    alu_op(rd, d, 1'b1);
                end
                default:
                begin
                    op = pick_load();
                    a  = pick_addr(op, 3);
                    rd = rand_bits(5);
                    mem_op(op, a, 32'd0, rd);
                end
            endcase
        end
        drain();
        for (int r = 0; r < 32; r++)
        begin
            check_reg(r);
        end
        report("back-to-back mix", c0, e0);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial
    begin
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        alu_result_i = '0;
        alu_oper2_i  = '0;
        mem_oper_i   = MEM_NOP;
        csr_wdata_i  = '0;
        csr_waddr_i  = '0;
        csr_we_i     = 1'b0;
        trap_i       = EXC_NONE;
        wb_use_mem_i = 1'b0;
        write_rd_i   = 1'b0;
        rd_addr_i    = '0;
        rs_addr_i    = '0;
        csr_raddr_i  = '0;
        for (int w = 0; w < `DMEM_WORDS; w++)
        begin
            m_mem[w] = '0;
        end
        for (int r = 0; r < 32; r++)
        begin
            m_regs[r] = '0;
        end
        m_mscratch = '0;
        m_mtvec    = '0;
        m_mcause   = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;

        word_roundtrip();
        lane_stores();
        load_extension();
        alu_writeback();
        csr_traps();
        mixed_stream();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule: mem_stage_tb

// File: mem_stage_top.f
+incdir+source
source/riscv_pkg.sv
source/data_mem.sv
source/mem_rw.sv
source/csr_file.sv
source/wb_regfile.sv
source/mem_stage_top.sv
sim/mem_stage_properties.sv
sim/mem_stage_tb.sv
